// ==== source/sched_pkg.sv ====
package sched_pkg;

	// ==============================
	// Reorder buffer sizing
	// ==============================

	localparam int ROB_ENTRIES = 8;
	localparam int NDX_W = $clog2(ROB_ENTRIES);

	typedef logic [NDX_W-1:0] rob_ndx_t;

	// One bit per reorder buffer entry
	typedef logic [ROB_ENTRIES-1:0] rob_mask_t;

	// ==============================
	// Instruction classes and ports
	// ==============================

	typedef enum logic [1:0] {
		CLASS_ALU = 2'd0,
		CLASS_FC  = 2'd1,
		CLASS_MEM = 2'd2
	} op_class_t;

	// Port numbering shared by the selector and the top level
	localparam int PORT_ALU0 = 0;
	localparam int PORT_ALU1 = 1;
	localparam int PORT_FCU  = 2;
	localparam int PORT_AGEN = 3;
	localparam int NUM_PORTS = 4;

endpackage

// ==== source/entry_store.sv ====
`timescale 1ns/1ns

module entry_store (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 disp_valid_i,
	input  sched_pkg::op_class_t disp_class_i,
	input  logic                 disp_args_ready_i,
	input  logic                 wake_valid_i,
	input  sched_pkg::rob_ndx_t  wake_ndx_i,
	input  logic                 done_valid_i,
	input  sched_pkg::rob_ndx_t  done_ndx_i,
	input  sched_pkg::rob_mask_t issue_mask_i,
	output logic                 disp_ready_o,
	output sched_pkg::rob_ndx_t  head_o,
	output sched_pkg::rob_mask_t valid_o,
	output sched_pkg::rob_mask_t args_ready_o,
	output sched_pkg::rob_mask_t issued_o,
	output sched_pkg::rob_mask_t done_o,
	output sched_pkg::rob_mask_t fc_pending_o,
	output sched_pkg::rob_mask_t mem_pending_o,
	output sched_pkg::op_class_t class_o [sched_pkg::ROB_ENTRIES]
);
	import sched_pkg::*;

	rob_ndx_t       head;
	rob_ndx_t       tail;
	logic [NDX_W:0] count;
	rob_mask_t      valid;
	rob_mask_t      args_ready;
	rob_mask_t      issued;
	rob_mask_t      done;
	op_class_t      cls [ROB_ENTRIES];
	logic           disp_fire;
	logic           retire;

	assign disp_ready_o = (count != ROB_ENTRIES);
	assign disp_fire = disp_valid_i && disp_ready_o;

	// Only the head may leave, and only once its unit has reported it
	assign retire = valid[head] && done[head];

	// ==============================
	// Entry state
	// ==============================

	always_ff @(posedge clk) begin
		if (rst) begin
			head <= '0;
			tail <= '0;
			count <= '0;
			valid <= '0;
			args_ready <= '0;
			issued <= '0;
			done <= '0;
		end else begin
			if (retire) begin
				valid[head] <= 1'b0;
				head <= head + rob_ndx_t'(1);
			end
			issued <= issued | issue_mask_i;
			if (done_valid_i)
				done[done_ndx_i] <= 1'b1;
			// A new entry starts with clean issue and completion flags
			if (disp_fire) begin
				valid[tail] <= 1'b1;
				args_ready[tail] <= disp_args_ready_i;
				issued[tail] <= 1'b0;
				done[tail] <= 1'b0;
				tail <= tail + rob_ndx_t'(1);
			end
			if (wake_valid_i)
				args_ready[wake_ndx_i] <= 1'b1;
			count <= count + (NDX_W+1)'(disp_fire) - (NDX_W+1)'(retire);
		end
	end

	always_ff @(posedge clk) begin
		if (disp_fire)
			cls[tail] <= disp_class_i;
	end

	// Entries that still hold back younger ops of the same class
	always_comb begin
		for (int i = 0; i < ROB_ENTRIES; i++) begin
			fc_pending_o[i] = valid[i] && !done[i] && (cls[i] == CLASS_FC);
			mem_pending_o[i] = valid[i] && !done[i] && (cls[i] == CLASS_MEM);
		end
	end

	assign head_o = head;
	assign valid_o = valid;
	assign args_ready_o = args_ready;
	assign issued_o = issued;
	assign done_o = done;
	assign class_o = cls;

	// An accepted dispatch never lands on a live entry
	a_no_overwrite: assert property (@(posedge clk) disable iff (rst)
		disp_fire |-> !valid[tail]);

endmodule

// ==== source/entry_ready.sv ====
`timescale 1ns/1ns

module entry_ready (
	input  logic                 clk,
	input  logic                 rst,
	input  sched_pkg::rob_ndx_t  my_ndx_i,
	input  sched_pkg::rob_ndx_t  head_i,
	input  logic                 valid_i,
	input  logic                 args_ready_i,
	input  logic                 issued_i,
	input  logic                 done_i,
	input  sched_pkg::op_class_t class_i,
	input  sched_pkg::rob_mask_t fc_pending_i,
	input  sched_pkg::rob_mask_t mem_pending_i,
	output logic                 ready_o
);
	import sched_pkg::*;

	rob_ndx_t  my_age;
	rob_mask_t older;
	logic      fc_block;
	logic      mem_block;
	logic      ready_next;

	// A smaller ring distance from the head means an older entry
	always_comb begin
		my_age = my_ndx_i - head_i;
		for (int j = 0; j < ROB_ENTRIES; j++)
			older[j] = rob_ndx_t'(j - head_i) < my_age;
	end

	// Flow control and memory ops wait for every older op of their class
	assign fc_block = (class_i == CLASS_FC) && |(fc_pending_i & older);
	assign mem_block = (class_i == CLASS_MEM) && |(mem_pending_i & older);

	assign ready_next = valid_i && args_ready_i && !issued_i && !done_i
		&& !fc_block && !mem_block;

	always_ff @(posedge clk) begin
		if (rst)
			ready_o <= 1'b0;
		else
			ready_o <= ready_next;
	end

	// A ready entry cannot retire in the same cycle because retiring needs done
	a_ready_valid: assert property (@(posedge clk) disable iff (rst)
		ready_o |-> valid_i);

endmodule

// ==== source/issue_select.sv ====
`timescale 1ns/1ns

module issue_select (
	input  logic                                clk,
	input  logic                                rst,
	input  sched_pkg::rob_mask_t                ready_i,
	input  sched_pkg::op_class_t                class_i [sched_pkg::ROB_ENTRIES],
	input  sched_pkg::rob_ndx_t                 head_i,
	input  logic [sched_pkg::NUM_PORTS-1:0]     port_free_i,
	output logic [sched_pkg::NUM_PORTS-1:0]     grant_v_o,
	output sched_pkg::rob_ndx_t                 grant_ndx_o [sched_pkg::NUM_PORTS],
	output sched_pkg::rob_mask_t                issue_mask_o
);
	import sched_pkg::*;

	rob_mask_t            recent_mask;
	rob_mask_t            cand;
	logic [NUM_PORTS-1:0] open;
	logic [NUM_PORTS-1:0] next_v;
	rob_ndx_t             next_ndx [NUM_PORTS];
	rob_mask_t            next_mask;
	rob_ndx_t             slot;
	int                   pick;
	logic                 pick_ok;

	// ==============================
	// Oldest-first scan
	// ==============================

	always_comb begin
		// Ready bits lag the issued flag by two cycles so recent grants are hidden
		cand = ready_i & ~issue_mask_o & ~recent_mask;
		// A port granted last cycle has not yet dropped its free bit
		open = port_free_i & ~grant_v_o;
		next_v = '0;
		next_mask = '0;
		slot = '0;
		pick = PORT_ALU0;
		pick_ok = 1'b0;
		for (int p = 0; p < NUM_PORTS; p++)
			next_ndx[p] = '0;
		for (int k = 0; k < ROB_ENTRIES; k++) begin
			slot = rob_ndx_t'(head_i + k);
			pick = PORT_ALU0;
			pick_ok = 1'b0;
			case (class_i[slot])
				CLASS_ALU: begin
					if (open[PORT_ALU0]) begin
						pick = PORT_ALU0;
						pick_ok = 1'b1;
					end else if (open[PORT_ALU1]) begin
						pick = PORT_ALU1;
						pick_ok = 1'b1;
					end
				end
				CLASS_FC: begin
					pick = PORT_FCU;
					pick_ok = open[PORT_FCU];
				end
				CLASS_MEM: begin
					pick = PORT_AGEN;
					pick_ok = open[PORT_AGEN];
				end
				default: pick_ok = 1'b0;
			endcase
			if (cand[slot] && pick_ok) begin
				open[pick] = 1'b0;
				next_v[pick] = 1'b1;
				next_ndx[pick] = slot;
				next_mask[slot] = 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			grant_v_o <= '0;
			issue_mask_o <= '0;
			recent_mask <= '0;
		end else begin
			grant_v_o <= next_v;
			issue_mask_o <= next_mask;
			recent_mask <= issue_mask_o;
		end
	end

	always_ff @(posedge clk) begin
		grant_ndx_o <= next_ndx;
	end

	a_alu_distinct: assert property (@(posedge clk) disable iff (rst)
		(grant_v_o[PORT_ALU0] && grant_v_o[PORT_ALU1])
		|-> (grant_ndx_o[PORT_ALU0] != grant_ndx_o[PORT_ALU1]));

endmodule

// ==== source/unit_port.sv ====
`timescale 1ns/1ns

module unit_port (
	input  logic                clk,
	input  logic                rst,
	input  logic                grant_v_i,
	input  sched_pkg::rob_ndx_t grant_ndx_i,
	input  logic                ack_i,
	output logic                free_o,
	output logic                req_o,
	output sched_pkg::rob_ndx_t ndx_o
);
	import sched_pkg::*;

	typedef enum logic [1:0] {
		IDLE,
		REQ,
		WAIT_ACK_LOW
	} port_state_t;

	port_state_t state;
	rob_ndx_t    ndx;
	logic        take;

	// The previous handshake must be fully closed before a new grant
	assign free_o = (state == IDLE) && !ack_i;
	assign take = free_o && grant_v_i;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= IDLE;
		end else begin
			case (state)
				IDLE:         if (take) state <= REQ;
				REQ:          if (ack_i) state <= WAIT_ACK_LOW;
				WAIT_ACK_LOW: if (!ack_i) state <= IDLE;
				default:      state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (take)
			ndx <= grant_ndx_i;
	end

	assign req_o = (state == REQ);
	assign ndx_o = ndx;

	a_ndx_hold: assert property (@(posedge clk) disable iff (rst)
		(req_o && !ack_i) |=> $stable(ndx_o));

endmodule

// ==== source/sched_top.sv ====
`timescale 1ns/1ns

module sched_top (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 disp_valid_i,
	input  sched_pkg::op_class_t disp_class_i,
	input  logic                 disp_args_ready_i,
	output logic                 disp_ready_o,
	input  logic                 wake_valid_i,
	input  sched_pkg::rob_ndx_t  wake_ndx_i,
	input  logic                 done_valid_i,
	input  sched_pkg::rob_ndx_t  done_ndx_i,
	output logic                 alu0_req_o,
	output sched_pkg::rob_ndx_t  alu0_ndx_o,
	input  logic                 alu0_ack_i,
	output logic                 alu1_req_o,
	output sched_pkg::rob_ndx_t  alu1_ndx_o,
	input  logic                 alu1_ack_i,
	output logic                 fcu_req_o,
	output sched_pkg::rob_ndx_t  fcu_ndx_o,
	input  logic                 fcu_ack_i,
	output logic                 agen_req_o,
	output sched_pkg::rob_ndx_t  agen_ndx_o,
	input  logic                 agen_ack_i
);
	sched_pkg::rob_ndx_t             head;
	sched_pkg::rob_mask_t            valid;
	sched_pkg::rob_mask_t            args_ready;
	sched_pkg::rob_mask_t            issued;
	sched_pkg::rob_mask_t            done;
	sched_pkg::rob_mask_t            fc_pending;
	sched_pkg::rob_mask_t            mem_pending;
	sched_pkg::rob_mask_t            ready;
	sched_pkg::rob_mask_t            issue_mask;
	sched_pkg::op_class_t            ent_class [sched_pkg::ROB_ENTRIES];
	logic [sched_pkg::NUM_PORTS-1:0] port_free;
	logic [sched_pkg::NUM_PORTS-1:0] grant_v;
	logic [sched_pkg::NUM_PORTS-1:0] port_req;
	logic [sched_pkg::NUM_PORTS-1:0] port_ack;
	sched_pkg::rob_ndx_t             grant_ndx [sched_pkg::NUM_PORTS];
	sched_pkg::rob_ndx_t             port_ndx [sched_pkg::NUM_PORTS];

	entry_store u_store (
		.clk, .rst, .disp_valid_i, .disp_class_i, .disp_args_ready_i,
		.wake_valid_i, .wake_ndx_i, .done_valid_i, .done_ndx_i,
		.issue_mask_i(issue_mask), .disp_ready_o, .head_o(head), .valid_o(valid),
		.args_ready_o(args_ready), .issued_o(issued), .done_o(done),
		.fc_pending_o(fc_pending), .mem_pending_o(mem_pending), .class_o(ent_class)
	);

	// One readiness cell per reorder buffer entry
	for (genvar g = 0; g < sched_pkg::ROB_ENTRIES; g++) begin : g_cell
		entry_ready u_ready (
			.clk, .rst, .my_ndx_i(sched_pkg::rob_ndx_t'(g)), .head_i(head),
			.valid_i(valid[g]), .args_ready_i(args_ready[g]), .issued_i(issued[g]),
			.done_i(done[g]), .class_i(ent_class[g]), .fc_pending_i(fc_pending),
			.mem_pending_i(mem_pending), .ready_o(ready[g])
		);
	end

	issue_select u_select (
		.clk, .rst, .ready_i(ready), .class_i(ent_class), .head_i(head),
		.port_free_i(port_free), .grant_v_o(grant_v), .grant_ndx_o(grant_ndx),
		.issue_mask_o(issue_mask)
	);

	for (genvar p = 0; p < sched_pkg::NUM_PORTS; p++) begin : g_port
		unit_port u_port (
			.clk, .rst, .grant_v_i(grant_v[p]), .grant_ndx_i(grant_ndx[p]),
			.ack_i(port_ack[p]), .free_o(port_free[p]), .req_o(port_req[p]),
			.ndx_o(port_ndx[p])
		);
	end

	assign port_ack[sched_pkg::PORT_ALU0] = alu0_ack_i;
	assign port_ack[sched_pkg::PORT_ALU1] = alu1_ack_i;
	assign port_ack[sched_pkg::PORT_FCU] = fcu_ack_i;
	assign port_ack[sched_pkg::PORT_AGEN] = agen_ack_i;

	assign alu0_req_o = port_req[sched_pkg::PORT_ALU0];
	assign alu0_ndx_o = port_ndx[sched_pkg::PORT_ALU0];
	assign alu1_req_o = port_req[sched_pkg::PORT_ALU1];
	assign alu1_ndx_o = port_ndx[sched_pkg::PORT_ALU1];
	assign fcu_req_o = port_req[sched_pkg::PORT_FCU];
	assign fcu_ndx_o = port_ndx[sched_pkg::PORT_FCU];
	assign agen_req_o = port_req[sched_pkg::PORT_AGEN];
	assign agen_ndx_o = port_ndx[sched_pkg::PORT_AGEN];

endmodule

// ==== verif/tb_sched_checks.sv ====
`timescale 1ns/1ns

module tb_sched_checks (
	input  logic                            clk,
	input  logic                            rst,
	input  logic [sched_pkg::NUM_PORTS-1:0] req_i,
	input  logic [sched_pkg::NUM_PORTS-1:0] ack_i,
	input  sched_pkg::rob_ndx_t             ndx_i [sched_pkg::NUM_PORTS],
	input  logic                            disp_ready_i,
	input  sched_pkg::rob_mask_t            ent_valid_i,
	input  sched_pkg::rob_mask_t            ent_args_i,
	input  sched_pkg::rob_mask_t            ent_done_i,
	input  sched_pkg::op_class_t            ent_class_i [sched_pkg::ROB_ENTRIES],
	input  int                              ent_seq_i [sched_pkg::ROB_ENTRIES],
	input  int                              ent_count_i,
	output int                              errs_o [5]
);
	import sched_pkg::*;

	string     names [NUM_PORTS] = '{"alu0", "alu1", "fcu", "agen"};
	int        errs [5] = '{default: 0};
	rob_mask_t blocked;

	assign errs_o = errs;

	// An FC or MEM entry is blocked while an older entry of its class is not done
	always_comb begin
		blocked = '0;
		for (int i = 0; i < ROB_ENTRIES; i++)
			for (int j = 0; j < ROB_ENTRIES; j++)
				if (ent_valid_i[j] && !ent_done_i[j] && ent_seq_i[j] < ent_seq_i[i]
					&& ent_class_i[j] == ent_class_i[i] && ent_class_i[i] != CLASS_ALU)
					blocked[i] = 1'b1;
	end

	function automatic op_class_t port_class(input int p);
		if (p == PORT_FCU)
			return CLASS_FC;
		if (p == PORT_AGEN)
			return CLASS_MEM;
		return CLASS_ALU;
	endfunction

	// ==============================
	// Per-port checks
	// ==============================

	for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port
		a_live: assert property (@(posedge clk) disable iff (rst)
			req_i[p] |-> ent_valid_i[ndx_i[p]] && ent_args_i[ndx_i[p]] && !ent_done_i[ndx_i[p]])
		else begin
			$display("ERROR %s_ndx_o 0x%h with valid 0x%h args 0x%h done 0x%h", names[p],
				$sampled(ndx_i[p]), $sampled(ent_valid_i), $sampled(ent_args_i),
				$sampled(ent_done_i));
			errs[1]++;
		end
		a_class: assert property (@(posedge clk) disable iff (rst)
			req_i[p] |-> ent_class_i[ndx_i[p]] == port_class(p))
		else begin
			$display("ERROR %s_ndx_o 0x%h has class 0x%h, expected 0x%h", names[p],
				$sampled(ndx_i[p]), $sampled(ent_class_i[ndx_i[p]]), port_class(p));
			errs[1]++;
		end
		a_hold: assert property (@(posedge clk) disable iff (rst)
			(req_i[p] && !ack_i[p]) |=> $stable(ndx_i[p]))
		else begin
			$display("ERROR %s_ndx_o 0x%h changed while req_o waited for ack", names[p],
				$sampled(ndx_i[p]));
			errs[2]++;
		end
		a_rise: assert property (@(posedge clk) disable iff (rst)
			$rose(req_i[p]) |-> !$past(ack_i[p]))
		else begin
			$display("%s_req_o rose before ack of the previous request fell", names[p]);
			errs[2]++;
		end
		if (p == PORT_FCU || p == PORT_AGEN) begin : g_order
			a_order: assert property (@(posedge clk) disable iff (rst)
				req_i[p] |-> !blocked[ndx_i[p]])
			else begin
				$display("ERROR %s_ndx_o 0x%h issued ahead of an older pending op, mask 0x%h",
					names[p], $sampled(ndx_i[p]), $sampled(blocked));
				errs[3]++;
			end
		end
	end

	a_alu_pair: assert property (@(posedge clk) disable iff (rst)
		(req_i[PORT_ALU0] && req_i[PORT_ALU1]) |-> ndx_i[PORT_ALU0] != ndx_i[PORT_ALU1])
	else begin
		$display("ERROR alu0_ndx_o 0x%h equals alu1_ndx_o 0x%h",
			$sampled(ndx_i[PORT_ALU0]), $sampled(ndx_i[PORT_ALU1]));
		errs[2]++;
	end

	a_reset: assert property (@(posedge clk)
		$fell(rst) |-> (req_i == '0) && disp_ready_i)
	else begin
		$display("ERROR req_o 0x%h disp_ready_o 0x%h in the first cycle after reset",
			$sampled(req_i), $sampled(disp_ready_i));
		errs[0]++;
	end

	// The ring is full exactly when eight entries are live
	a_full: assert property (@(posedge clk) disable iff (rst)
		disp_ready_i == (ent_count_i != ROB_ENTRIES))
	else begin
		$display("ERROR disp_ready_o 0x%h with 0x%h entries in the ring",
			$sampled(disp_ready_i), $sampled(ent_count_i));
		errs[4]++;
	end

endmodule

// ==== verif/tb_sched.sv ====
`timescale 1ns/1ns

module tb_sched;
	import sched_pkg::*;

	localparam int RANDOM_INSTR = 120;
	localparam int PLANNED = ROB_ENTRIES + RANDOM_INSTR;
	localparam int CYCLE_LIMIT = 50 * PLANNED + 100;

	logic                 clk = 1'b0;
	logic                 rst;
	logic                 disp_valid;
	logic                 disp_args;
	logic                 disp_fire;
	op_class_t            disp_class;
	logic                 disp_ready;
	logic                 wake_valid;
	logic                 done_valid;
	rob_ndx_t             wake_ndx;
	rob_ndx_t             done_ndx;
	wire [NUM_PORTS-1:0]  req;
	wire rob_ndx_t        ndx [NUM_PORTS];
	logic [NUM_PORTS-1:0] ack = '0;
	logic [NUM_PORTS-1:0] req_prev = '0;
	int                   ack_wait [NUM_PORTS] = '{default: 0};
	int                   errs [5];
	logic [31:0]          lfsr = 32'hb321;
	int                   cycle_n = 0;

	// The reference ring follows the allocation rule
	rob_ndx_t  head = '0;
	rob_ndx_t  tail = '0;
	int        count = 0;
	int        seq = 0;
	rob_mask_t ent_valid = '0;
	rob_mask_t ent_args = '0;
	rob_mask_t ent_done = '0;
	op_class_t ent_class [ROB_ENTRIES] = '{default: CLASS_ALU};
	int        ent_seq [ROB_ENTRIES] = '{default: 0};
	int        req_seen [ROB_ENTRIES] = '{default: 0};
	int        due_q [$];
	rob_ndx_t  done_q [$];
	int        issued_total = 0;
	int        dups = 0;

	sched_top i_dut (
		.clk, .rst, .disp_valid_i(disp_valid), .disp_class_i(disp_class),
		.disp_args_ready_i(disp_args), .disp_ready_o(disp_ready),
		.wake_valid_i(wake_valid), .wake_ndx_i(wake_ndx),
		.done_valid_i(done_valid), .done_ndx_i(done_ndx),
		.alu0_req_o(req[PORT_ALU0]), .alu0_ndx_o(ndx[PORT_ALU0]), .alu0_ack_i(ack[PORT_ALU0]),
		.alu1_req_o(req[PORT_ALU1]), .alu1_ndx_o(ndx[PORT_ALU1]), .alu1_ack_i(ack[PORT_ALU1]),
		.fcu_req_o(req[PORT_FCU]), .fcu_ndx_o(ndx[PORT_FCU]), .fcu_ack_i(ack[PORT_FCU]),
		.agen_req_o(req[PORT_AGEN]), .agen_ndx_o(ndx[PORT_AGEN]), .agen_ack_i(ack[PORT_AGEN])
	);

	tb_sched_checks i_checks (
		.clk, .rst, .req_i(req), .ack_i(ack), .ndx_i(ndx), .disp_ready_i(disp_ready),
		.ent_valid_i(ent_valid), .ent_args_i(ent_args), .ent_done_i(ent_done),
		.ent_class_i(ent_class), .ent_seq_i(ent_seq), .ent_count_i(count), .errs_o(errs)
	);

	always #4 clk = ~clk;

	always @(posedge clk) begin
		cycle_n <= cycle_n + 1;
		if (cycle_n >= CYCLE_LIMIT) begin
			$display("Run stopped at cycle limit %0d with %0d entries in flight", cycle_n, count);
			$display("Verification failed");
			$finish;
		end
	end

	// Galois LFSR that steps once per bit taken
	function automatic int take_bits(input int n);
		int v;
		v = 0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'h8020_0003 : lfsr >> 1;
			v = (v << 1) | lfsr[0];
		end
		return v;
	endfunction

	function automatic op_class_t pick_class();
		int v;
		v = take_bits(2);
		if (v == 1)
			return CLASS_FC;
		if (v == 2)
			return CLASS_MEM;
		return CLASS_ALU;
	endfunction

	// ==============================
	// Unit models
	// ==============================

	task automatic run_units();
		for (int p = 0; p < NUM_PORTS; p++) begin
			if (req[p] && !req_prev[p]) begin
				issued_total++;
				if (req_seen[ndx[p]] > 0)
					dups++;
				req_seen[ndx[p]]++;
				ack_wait[p] = take_bits(2);
			end
			if (req[p] && !ack[p]) begin
				if (ack_wait[p] == 0) begin
					ack[p] = 1'b1;
					// The same counter then holds ack for a while after req falls
					ack_wait[p] = take_bits(2);
					due_q.push_back(cycle_n + take_bits(2));
					done_q.push_back(ndx[p]);
				end else begin
					ack_wait[p]--;
				end
			end else if (!req[p] && ack[p]) begin
				if (ack_wait[p] == 0)
					ack[p] = 1'b0;
				else
					ack_wait[p]--;
			end
			req_prev[p] = req[p];
		end
		// One completion per cycle shares the single done input
		done_valid = 1'b0;
		if (due_q.size() > 0 && due_q[0] <= cycle_n) begin
			done_valid = 1'b1;
			done_ndx = done_q.pop_front();
			void'(due_q.pop_front());
		end
	endtask

	// Applies the edge just passed to the reference ring, then answers the units
	task automatic advance();
		logic retire;
		@(posedge clk);
		#1;
		retire = ent_valid[head] && ent_done[head];
		if (retire) begin
			ent_valid[head] = 1'b0;
			head++;
			count--;
		end
		if (done_valid)
			ent_done[done_ndx] = 1'b1;
		if (disp_fire) begin
			ent_valid[tail] = 1'b1;
			ent_args[tail] = disp_args;
			ent_done[tail] = 1'b0;
			ent_class[tail] = disp_class;
			ent_seq[tail] = seq;
			req_seen[tail] = 0;
			seq++;
			tail++;
			count++;
		end
		if (wake_valid)
			ent_args[wake_ndx] = 1'b1;
		run_units();
	endtask

	initial begin
		int fails;
		int losses;
		int end_errs;
		end_errs = 0;
		rst = 1'b1;
		disp_valid = 1'b0;
		disp_class = CLASS_ALU;
		disp_args = 1'b0;
		disp_fire = 1'b0;
		wake_valid = 1'b0;
		wake_ndx = '0;
		done_valid = 1'b0;
		done_ndx = '0;
		repeat (5) advance();
		rst = 1'b0;
		advance();
		$display("Test 1 reset state: %0d errors", errs[0]);

		// Operands held back so the ring fills with nothing to issue
		repeat (ROB_ENTRIES + 3) begin
			disp_valid = 1'b1;
			disp_class = pick_class();
			disp_args = 1'b0;
			disp_fire = disp_ready;
			advance();
		end

		while (seq < PLANNED) begin
			disp_valid = take_bits(2) != 0;
			disp_class = pick_class();
			disp_args = take_bits(1) != 0;
			disp_fire = disp_valid && disp_ready;
			wake_ndx = rob_ndx_t'(take_bits(3));
			wake_valid = take_bits(1) != 0 && ent_valid[wake_ndx] && !ent_args[wake_ndx];
			advance();
		end

		// Drain with every waiting entry woken
		disp_valid = 1'b0;
		disp_fire = 1'b0;
		while (count > 0 || due_q.size() > 0) begin
			wake_valid = 1'b0;
			for (int i = 0; i < ROB_ENTRIES; i++) begin
				if (ent_valid[i] && !ent_args[i]) begin
					wake_valid = 1'b1;
					wake_ndx = rob_ndx_t'(i);
				end
			end
			advance();
		end
		wake_valid = 1'b0;
		repeat (3) advance();
		$display("Test 2 operand and class rule: %0d errors", errs[1]);
		$display("Test 3 handshake: %0d errors", errs[2]);
		$display("Test 4 program order: %0d errors", errs[3]);

		losses = seq - (issued_total - dups);
		a_idle: assert (disp_ready)
		else begin
			$display("ERROR disp_ready_o 0x%h after drain, expected 0x1", disp_ready);
			end_errs++;
		end
		a_dups: assert (dups == 0)
		else begin
			$display("%0d requests named an entry that was already requested", dups);
			end_errs++;
		end
		a_losses: assert (losses == 0)
		else begin
			$display("%0d dispatched entries were never requested", losses);
			end_errs++;
		end
		$display("Test 5 completeness: %0d dispatched, %0d duplicates, %0d losses, %0d errors",
			seq, dups, losses, errs[4] + end_errs);

		fails = errs[0] + errs[1] + errs[2] + errs[3] + errs[4] + end_errs;
		$display("Checks failed: %0d over %0d instructions in %0d cycles", fails, seq, cycle_n);
		if (fails == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

// ==== files.f ====
source/sched_pkg.sv
source/entry_store.sv
source/entry_ready.sv
source/issue_select.sv
source/unit_port.sv
source/sched_top.sv
verif/tb_sched_checks.sv
verif/tb_sched.sv
